// File: bench/rvfi_trace_checks.sv
// Reference model and checks for the retirement tracer
// Queues expected ID and EX records and compares each trace record one cycle after WB
`timescale 1ns/1ns

module rvfi_trace_checks (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        id_valid_i,
  input  logic [31:0] pc_id_i, insn_id_i, operand_a_fw_id_i, operand_b_fw_id_i,
  input  logic        ex_valid_i, lsu_en_ex_i, lsu_we_ex_i, branch_taken_ex_i,
  input  logic [1:0]  lsu_size_ex_i,
  input  logic [31:0] data_addr_ex_i, data_wdata_ex_i, branch_target_ex_i,
  input  logic        wb_valid_i, rf_we_wb_i,
  input  logic [31:0] rf_wdata_wb_i, lsu_rdata_wb_i,
  input  logic        rvfi_valid_i,
  input  logic [63:0] rvfi_order_i,
  input  logic [31:0] rvfi_insn_i, rvfi_pc_rdata_i, rvfi_pc_wdata_i,
  input  logic [4:0]  rvfi_rs1_addr_i, rvfi_rs2_addr_i, rvfi_rd_addr_i,
  input  logic [31:0] rvfi_rs1_rdata_i, rvfi_rs2_rdata_i, rvfi_rd_wdata_i,
  input  logic [31:0] rvfi_mem_addr_i, rvfi_mem_rdata_i, rvfi_mem_wdata_i,
  input  logic [3:0]  rvfi_mem_rmask_i, rvfi_mem_wmask_i,
  output logic        error_o
);

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] insn;
    logic [4:0]  rs1_a;
    logic [4:0]  rs2_a;
    logic [31:0] rs1_d;
    logic [31:0] rs2_d;
  } id_exp_t;

  typedef struct packed {
    logic        taken;
    logic [31:0] target;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  rmask;
    logic [3:0]  wmask;
  } ex_exp_t;

  id_exp_t     id_fifo[$];
  ex_exp_t     ex_fifo[$];
  id_exp_t     id_head;
  ex_exp_t     ex_head;
  id_exp_t     id_new;
  ex_exp_t     ex_new;
  logic        exp_valid;
  logic [63:0] exp_order;
  logic [4:0]  exp_rd;
  logic [31:0] exp_rd_wdata;
  logic [31:0] exp_pc_next;
  logic [31:0] exp_mem_rdata;

  initial error_o = 1'b0;

  function automatic logic [31:0] keep_lanes(input logic [31:0] d, input logic [3:0] m);
    return {m[3] ? d[31:24] : 8'h00, m[2] ? d[23:16] : 8'h00,
            m[1] ? d[15:8] : 8'h00, m[0] ? d[7:0] : 8'h00};
  endfunction

  function automatic logic [3:0] lane_mask(input logic [1:0] size, input logic [1:0] off);
    logic [3:0] m;
    case (size)
      2'd0:    m = 4'b0001;
      2'd1:    m = 4'b0011;
      default: m = 4'b1111;
    endcase
    return m << off;
  endfunction

  task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, got);
      error_o = 1'b1;
    end
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      id_fifo.delete();
      ex_fifo.delete();
      exp_valid = 1'b0;
      exp_order = '0;
    end else begin
      // Outputs seen here were registered at the previous edge
      check_field("rvfi_valid", rvfi_valid_i, exp_valid);
      if (exp_valid) begin
        check_field("rvfi_order", rvfi_order_i, exp_order - 1);
        check_field("rvfi_insn", rvfi_insn_i, id_head.insn);
        check_field("rvfi_pc_rdata", rvfi_pc_rdata_i, id_head.pc);
        check_field("rvfi_pc_wdata", rvfi_pc_wdata_i, exp_pc_next);
        check_field("rvfi_rs1_addr", rvfi_rs1_addr_i, id_head.rs1_a);
        check_field("rvfi_rs2_addr", rvfi_rs2_addr_i, id_head.rs2_a);
        check_field("rvfi_rs1_rdata", rvfi_rs1_rdata_i, id_head.rs1_d);
        check_field("rvfi_rs2_rdata", rvfi_rs2_rdata_i, id_head.rs2_d);
        check_field("rvfi_rd_addr", rvfi_rd_addr_i, exp_rd);
        check_field("rvfi_rd_wdata", rvfi_rd_wdata_i, exp_rd_wdata);
        check_field("rvfi_mem_addr", rvfi_mem_addr_i, ex_head.addr);
        check_field("rvfi_mem_rmask", rvfi_mem_rmask_i, ex_head.rmask);
        check_field("rvfi_mem_wmask", rvfi_mem_wmask_i, ex_head.wmask);
        check_field("rvfi_mem_rdata", rvfi_mem_rdata_i, exp_mem_rdata);
        check_field("rvfi_mem_wdata", rvfi_mem_wdata_i, ex_head.wdata);
      end
      exp_valid = wb_valid_i;
      if (wb_valid_i) begin
        if (id_fifo.size() == 0 || ex_fifo.size() == 0) begin
          $display("WB strobe at %0t arrived with no matching ID or EX record", $time);
          error_o = 1'b1;
        end else begin
          id_head = id_fifo.pop_front();
          ex_head = ex_fifo.pop_front();
          exp_rd = (rf_we_wb_i && id_head.insn[11:7] != 5'd0) ? id_head.insn[11:7] : 5'd0;
          exp_rd_wdata = (exp_rd != 5'd0) ? rf_wdata_wb_i : 32'd0;
          exp_pc_next = ex_head.taken ? ex_head.target : id_head.pc + 32'd4;
          exp_mem_rdata = keep_lanes(lsu_rdata_wb_i, ex_head.rmask);
          exp_order = exp_order + 1;
        end
      end
      if (id_valid_i) begin
        id_new.pc = pc_id_i;
        id_new.insn = insn_id_i;
        // LUI, AUIPC and JAL read no rs1; only BRANCH, STORE and OP read rs2
        id_new.rs1_a = (insn_id_i[6:0] inside {7'b0110111, 7'b0010111, 7'b1101111})
                       ? 5'd0 : insn_id_i[19:15];
        id_new.rs2_a = (insn_id_i[6:0] inside {7'b1100011, 7'b0100011, 7'b0110011})
                       ? insn_id_i[24:20] : 5'd0;
        id_new.rs1_d = (id_new.rs1_a != 5'd0) ? operand_a_fw_id_i : 32'd0;
        id_new.rs2_d = (id_new.rs2_a != 5'd0) ? operand_b_fw_id_i : 32'd0;
        id_fifo.push_back(id_new);
      end
      if (ex_valid_i) begin
        ex_new.taken = branch_taken_ex_i;
        ex_new.target = branch_target_ex_i;
        ex_new.addr = lsu_en_ex_i ? data_addr_ex_i : 32'd0;
        ex_new.rmask = (lsu_en_ex_i && !lsu_we_ex_i)
                       ? lane_mask(lsu_size_ex_i, data_addr_ex_i[1:0]) : 4'd0;
        ex_new.wmask = (lsu_en_ex_i && lsu_we_ex_i)
                       ? lane_mask(lsu_size_ex_i, data_addr_ex_i[1:0]) : 4'd0;
        ex_new.wdata = keep_lanes(data_wdata_ex_i, ex_new.wmask);
        ex_fifo.push_back(ex_new);
      end
    end
  end

endmodule

// File: bench/rvfi_trace_tb.sv
// Testbench for the retirement tracer
// Random RV32I instructions with up to three in flight between ID, EX and WB
`timescale 1ns/1ns

module rvfi_trace_tb;

  localparam int NUM_INSNS  = 300;
  localparam int MAX_CYCLES = NUM_INSNS * 12;

  logic        clk_i = 1'b0;
  logic        reset_i;
  logic        id_valid_i, ex_valid_i, wb_valid_i;
  logic [31:0] pc_id_i, insn_id_i, operand_a_fw_id_i, operand_b_fw_id_i;
  logic        lsu_en_ex_i, lsu_we_ex_i, branch_taken_ex_i;
  logic [1:0]  lsu_size_ex_i;
  logic [31:0] data_addr_ex_i, data_wdata_ex_i, branch_target_ex_i;
  logic        rf_we_wb_i;
  logic [31:0] rf_wdata_wb_i, lsu_rdata_wb_i;
  logic        rvfi_valid_o;
  logic [63:0] rvfi_order_o;
  logic [31:0] rvfi_insn_o, rvfi_pc_rdata_o, rvfi_pc_wdata_o;
  logic [4:0]  rvfi_rs1_addr_o, rvfi_rs2_addr_o, rvfi_rd_addr_o;
  logic [31:0] rvfi_rs1_rdata_o, rvfi_rs2_rdata_o, rvfi_rd_wdata_o;
  logic [31:0] rvfi_mem_addr_o, rvfi_mem_rdata_o, rvfi_mem_wdata_o;
  logic [3:0]  rvfi_mem_rmask_o, rvfi_mem_wmask_o;
  logic        check_error;

  logic [6:0]  opcodes [10];
  logic [6:0]  op_hist [NUM_INSNS];
  logic [31:0] rnd;
  logic [31:0] word;
  logic [6:0]  op;
  int          id_cnt, ex_cnt, wb_cnt, cycles;
  logic        fire_id, fire_ex, fire_wb;

  rvfi_trace uut (.*);

  rvfi_trace_checks checks (
    .clk_i (clk_i), .reset_i (reset_i),
    .id_valid_i (id_valid_i), .pc_id_i (pc_id_i), .insn_id_i (insn_id_i),
    .operand_a_fw_id_i (operand_a_fw_id_i), .operand_b_fw_id_i (operand_b_fw_id_i),
    .ex_valid_i (ex_valid_i), .lsu_en_ex_i (lsu_en_ex_i), .lsu_we_ex_i (lsu_we_ex_i),
    .branch_taken_ex_i (branch_taken_ex_i), .lsu_size_ex_i (lsu_size_ex_i),
    .data_addr_ex_i (data_addr_ex_i), .data_wdata_ex_i (data_wdata_ex_i),
    .branch_target_ex_i (branch_target_ex_i),
    .wb_valid_i (wb_valid_i), .rf_we_wb_i (rf_we_wb_i),
    .rf_wdata_wb_i (rf_wdata_wb_i), .lsu_rdata_wb_i (lsu_rdata_wb_i),
    .rvfi_valid_i (rvfi_valid_o), .rvfi_order_i (rvfi_order_o),
    .rvfi_insn_i (rvfi_insn_o), .rvfi_pc_rdata_i (rvfi_pc_rdata_o),
    .rvfi_pc_wdata_i (rvfi_pc_wdata_o),
    .rvfi_rs1_addr_i (rvfi_rs1_addr_o), .rvfi_rs2_addr_i (rvfi_rs2_addr_o),
    .rvfi_rd_addr_i (rvfi_rd_addr_o),
    .rvfi_rs1_rdata_i (rvfi_rs1_rdata_o), .rvfi_rs2_rdata_i (rvfi_rs2_rdata_o),
    .rvfi_rd_wdata_i (rvfi_rd_wdata_o),
    .rvfi_mem_addr_i (rvfi_mem_addr_o), .rvfi_mem_rdata_i (rvfi_mem_rdata_o),
    .rvfi_mem_wdata_i (rvfi_mem_wdata_o),
    .rvfi_mem_rmask_i (rvfi_mem_rmask_o), .rvfi_mem_wmask_i (rvfi_mem_wmask_o),
    .error_o (check_error)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: only %0d of %0d instructions retired", wb_cnt, NUM_INSNS);
      $display("Regression failed");
      $fatal(1, "run stopped by timeout");
    end
  end

  always @(posedge check_error) begin
    $display("Regression failed");
    $fatal(1, "run stopped at first error");
  end

  initial begin
    opcodes = '{rvfi_pkg::OPC_LUI, rvfi_pkg::OPC_AUIPC, rvfi_pkg::OPC_JAL,
                rvfi_pkg::OPC_JALR, rvfi_pkg::OPC_BRANCH, rvfi_pkg::OPC_LOAD,
                rvfi_pkg::OPC_STORE, rvfi_pkg::OPC_OP_IMM, rvfi_pkg::OPC_OP,
                rvfi_pkg::OPC_SYSTEM};
    {id_valid_i, ex_valid_i, wb_valid_i, lsu_en_ex_i, lsu_we_ex_i} = '0;
    {pc_id_i, insn_id_i, operand_a_fw_id_i, operand_b_fw_id_i} = '0;
    {branch_taken_ex_i, lsu_size_ex_i, data_addr_ex_i, data_wdata_ex_i} = '0;
    {branch_target_ex_i, rf_we_wb_i, rf_wdata_wb_i, lsu_rdata_wb_i} = '0;
    rnd = 32'hdaa4;
    id_cnt = 0;
    ex_cnt = 0;
    wb_cnt = 0;
    cycles = 0;
    reset_i = 1'b1;
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    while (wb_cnt < NUM_INSNS) begin
      @(posedge clk_i);
      rnd = xorshift(rnd);
      // Stage enables use counts from earlier cycles, so WB trails EX trails ID
      fire_wb = (wb_cnt < ex_cnt) && (rnd[0] || rnd[1]);
      fire_ex = (ex_cnt < id_cnt) && (rnd[2] || rnd[3]);
      fire_id = (id_cnt < NUM_INSNS) && (id_cnt - wb_cnt < 3) && (rnd[4] || rnd[5]);
      id_valid_i <= fire_id;
      ex_valid_i <= fire_ex;
      wb_valid_i <= fire_wb;
      if (fire_id) begin
        rnd = xorshift(rnd);
        op = opcodes[rnd % 10];
        op_hist[id_cnt] = op;
        rnd = xorshift(rnd);
        word = {rnd[31:7], op};
        rnd = xorshift(rnd);
        // Steer some register fields to x0
        if (rnd[2:0] == 3'd0) word[19:15] = 5'd0;
        if (rnd[5:3] == 3'd0) word[24:20] = 5'd0;
        if (rnd[8:6] == 3'd0) word[11:7] = 5'd0;
        insn_id_i <= word;
        rnd = xorshift(rnd);
        pc_id_i <= {rnd[31:2], 2'b00};
        rnd = xorshift(rnd);
        operand_a_fw_id_i <= rnd;
        rnd = xorshift(rnd);
        operand_b_fw_id_i <= rnd;
        id_cnt = id_cnt + 1;
      end
      if (fire_ex) begin
        op = op_hist[ex_cnt];
        lsu_en_ex_i <= (op == rvfi_pkg::OPC_LOAD) || (op == rvfi_pkg::OPC_STORE);
        lsu_we_ex_i <= (op == rvfi_pkg::OPC_STORE);
        rnd = xorshift(rnd);
        lsu_size_ex_i <= 2'(rnd % 3);
        case (rnd % 3)
          0:       data_addr_ex_i <= xorshift(rnd);
          1:       data_addr_ex_i <= xorshift(rnd) & 32'hffff_fffe;
          default: data_addr_ex_i <= xorshift(rnd) & 32'hffff_fffc;
        endcase
        rnd = xorshift(rnd);
        rnd = xorshift(rnd);
        data_wdata_ex_i <= rnd;
        branch_taken_ex_i <= rnd[7] && (op inside {rvfi_pkg::OPC_BRANCH,
                                                  rvfi_pkg::OPC_JAL, rvfi_pkg::OPC_JALR});
        rnd = xorshift(rnd);
        branch_target_ex_i <= {rnd[31:2], 2'b00};
        ex_cnt = ex_cnt + 1;
      end
      if (fire_wb) begin
        rnd = xorshift(rnd);
        rf_we_wb_i <= rnd[3];
        rf_wdata_wb_i <= xorshift(rnd);
        rnd = xorshift(rnd);
        lsu_rdata_wb_i <= xorshift(rnd);
        wb_cnt = wb_cnt + 1;
      end
    end
    @(posedge clk_i);
    id_valid_i <= 1'b0;
    ex_valid_i <= 1'b0;
    wb_valid_i <= 1'b0;
    repeat (3) @(posedge clk_i);
    if (check_error) begin
      $display("Regression failed");
      $fatal(1, "checks reported an error");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

// File: list.f
+incdir+source
source/rvfi_pkg.sv
source/rvfi_queue_if.sv
source/rvfi_stage_fifo.sv
source/rvfi_id_capture.sv
source/rvfi_ex_capture.sv
source/rvfi_retire.sv
source/rvfi_trace.sv
bench/rvfi_trace_checks.sv
bench/rvfi_trace_tb.sv

// File: source/rvfi_ex_capture.sv
// EX-stage capture
// Builds the byte masks, masked write data and branch outcome of the EX record
`timescale 1ns/1ns
`include "rvfi_settings.svh"

module rvfi_ex_capture (
  input  logic                  clk_i,
  input  logic                  ex_valid_i,
  input  logic                  lsu_en_ex_i,
  input  logic                  lsu_we_ex_i,
  input  rvfi_pkg::mem_size_e   lsu_size_ex_i,
  input  logic [`RVFI_XLEN-1:0] data_addr_ex_i,
  input  logic [`RVFI_XLEN-1:0] data_wdata_ex_i,
  input  logic                  branch_taken_ex_i,
  input  logic [`RVFI_XLEN-1:0] branch_target_ex_i,
  rvfi_queue_if.producer        q
);

  localparam int MASK_W = `RVFI_XLEN / 8;

  logic [MASK_W-1:0] size_mask;
  logic [MASK_W-1:0] byte_mask;
  logic [1:0]        align_bits;
  rvfi_pkg::ex_rec_t rec;

  always_comb begin
    case (lsu_size_ex_i)
      rvfi_pkg::SIZE_BYTE: begin
        size_mask  = MASK_W'(4'h1);
        align_bits = 2'b00;
      end
      rvfi_pkg::SIZE_HALF: begin
        size_mask  = MASK_W'(4'h3);
        align_bits = 2'b01;
      end
      rvfi_pkg::SIZE_WORD: begin
        size_mask  = MASK_W'(4'hf);
        align_bits = 2'b11;
      end
      default: begin
        size_mask  = '0;
        align_bits = 2'b11;
      end
    endcase
  end

  // Lanes touched by the access
  assign byte_mask = size_mask << data_addr_ex_i[1:0];

  always_comb begin
    rec.branch_taken  = branch_taken_ex_i;
    rec.branch_target = branch_target_ex_i;
    rec.mem_addr      = lsu_en_ex_i ? data_addr_ex_i : '0;
    rec.mem_rmask     = (lsu_en_ex_i && !lsu_we_ex_i) ? byte_mask : '0;
    rec.mem_wmask     = (lsu_en_ex_i && lsu_we_ex_i) ? byte_mask : '0;
    rec.mem_wdata     = rvfi_pkg::mask_bytes(data_wdata_ex_i, rec.mem_wmask);
  end

  assign q.push      = ex_valid_i;
  assign q.push_data = rec;

  // Misaligned accesses would be split by the LSU, which this tracer does not model
  a_aligned: assert property (@(posedge clk_i)
    ex_valid_i && lsu_en_ex_i |-> (data_addr_ex_i[1:0] & align_bits) == 2'b00);

endmodule

// File: source/rvfi_id_capture.sv
// ID-stage capture
// Works out which source registers the opcode reads and pushes the ID record
`timescale 1ns/1ns
`include "rvfi_settings.svh"

module rvfi_id_capture (
  input  logic                  id_valid_i,
  input  logic [`RVFI_XLEN-1:0] pc_id_i,
  input  rvfi_pkg::insn_word_u  insn_id_i,
  input  logic [`RVFI_XLEN-1:0] operand_a_fw_id_i,
  input  logic [`RVFI_XLEN-1:0] operand_b_fw_id_i,
  rvfi_queue_if.producer        q
);

  rvfi_pkg::opcode_e opcode;
  logic              rs1_used;
  logic              rs2_used;
  logic              opcode_known;
  rvfi_pkg::id_rec_t rec;

  assign opcode = insn_id_i.fields.opcode;

  // U-type and JAL have no rs1 field
  assign rs1_used = !(opcode inside {rvfi_pkg::OPC_LUI,
                                     rvfi_pkg::OPC_AUIPC,
                                     rvfi_pkg::OPC_JAL});

  assign rs2_used = opcode inside {rvfi_pkg::OPC_BRANCH,
                                   rvfi_pkg::OPC_STORE,
                                   rvfi_pkg::OPC_OP};

  assign opcode_known = opcode inside {rvfi_pkg::OPC_LUI, rvfi_pkg::OPC_AUIPC,
                                       rvfi_pkg::OPC_JAL, rvfi_pkg::OPC_JALR,
                                       rvfi_pkg::OPC_BRANCH, rvfi_pkg::OPC_LOAD,
                                       rvfi_pkg::OPC_STORE, rvfi_pkg::OPC_OP_IMM,
                                       rvfi_pkg::OPC_OP, rvfi_pkg::OPC_SYSTEM};

  always_comb begin
    rec.pc        = pc_id_i;
    rec.insn      = insn_id_i;
    rec.rs1_addr  = rs1_used ? insn_id_i.fields.rs1 : 5'd0;
    rec.rs2_addr  = rs2_used ? insn_id_i.fields.rs2 : 5'd0;
    // x0 always reads as zero whatever the forwarding path holds
    rec.rs1_rdata = (rec.rs1_addr != 5'd0) ? operand_a_fw_id_i : '0;
    rec.rs2_rdata = (rec.rs2_addr != 5'd0) ? operand_b_fw_id_i : '0;
  end

  assign q.push      = id_valid_i;
  assign q.push_data = rec;

  // Upstream decode only lets base RV32I opcodes through ID
  a_known_opcode: assert final (!id_valid_i || opcode_known);

endmodule

// File: source/rvfi_pkg.sv
// Retirement tracer types
// Instruction word views, opcode and access size encodings, stage records
`include "rvfi_settings.svh"

package rvfi_pkg;

  // Base opcodes of RV32I
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } mem_size_e;

  // Field view in R-type layout
  // The rd and rs fields sit at the same place in every format
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } insn_fields_t;

  typedef union packed {
    logic [31:0]  raw;
    insn_fields_t fields;
  } insn_word_u;

  typedef struct packed {
    logic [`RVFI_XLEN-1:0] pc;
    insn_word_u            insn;
    logic [4:0]            rs1_addr;
    logic [4:0]            rs2_addr;
    logic [`RVFI_XLEN-1:0] rs1_rdata;
    logic [`RVFI_XLEN-1:0] rs2_rdata;
  } id_rec_t;

  typedef struct packed {
    logic                    branch_taken;
    logic [`RVFI_XLEN-1:0]   branch_target;
    logic [`RVFI_XLEN-1:0]   mem_addr;
    logic [`RVFI_XLEN/8-1:0] mem_rmask;
    logic [`RVFI_XLEN/8-1:0] mem_wmask;
    logic [`RVFI_XLEN-1:0]   mem_wdata;
  } ex_rec_t;

  // Zero every byte lane whose mask bit is clear
  function automatic logic [`RVFI_XLEN-1:0] mask_bytes(
    input logic [`RVFI_XLEN-1:0]   data,
    input logic [`RVFI_XLEN/8-1:0] mask
  );
    logic [`RVFI_XLEN-1:0] res;
    for (int i = 0; i < `RVFI_XLEN/8; i++) begin
      res[8*i +: 8] = mask[i] ? data[8*i +: 8] : 8'h00;
    end
    return res;
  endfunction

endpackage

// File: source/rvfi_queue_if.sv
// Record queue link between a stage capture, its FIFO and the retire stage
`timescale 1ns/1ns

interface rvfi_queue_if #(
  parameter int WIDTH = 32
);

  logic             push;
  logic [WIDTH-1:0] push_data;
  logic             pop;
  logic [WIDTH-1:0] pop_data;
  logic             empty;
  logic             full;

  // Capture side with a one-cycle push strobe
  modport producer (
    output push,
    output push_data
  );

  modport store (
    input  push,
    input  push_data,
    input  pop,
    output pop_data,
    output empty,
    output full
  );

  // Retire side reads the head on pop_data
  modport consumer (
    output pop,
    input  pop_data,
    input  empty
  );

endinterface

// File: source/rvfi_retire.sv
// Retire stage of the tracer
// Merges the head ID and EX records with WB data into one registered trace record
`timescale 1ns/1ns
`include "rvfi_settings.svh"

module rvfi_retire (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      wb_valid_i,
  input  logic                      rf_we_wb_i,
  input  logic [`RVFI_XLEN-1:0]     rf_wdata_wb_i,
  input  logic [`RVFI_XLEN-1:0]     lsu_rdata_wb_i,
  rvfi_queue_if.consumer            id_q,
  rvfi_queue_if.consumer            ex_q,
  output logic                      rvfi_valid_o,
  output logic [`RVFI_ORDER_W-1:0]  rvfi_order_o,
  output logic [31:0]               rvfi_insn_o,
  output logic [`RVFI_XLEN-1:0]     rvfi_pc_rdata_o,
  output logic [`RVFI_XLEN-1:0]     rvfi_pc_wdata_o,
  output logic [4:0]                rvfi_rs1_addr_o,
  output logic [4:0]                rvfi_rs2_addr_o,
  output logic [`RVFI_XLEN-1:0]     rvfi_rs1_rdata_o,
  output logic [`RVFI_XLEN-1:0]     rvfi_rs2_rdata_o,
  output logic [4:0]                rvfi_rd_addr_o,
  output logic [`RVFI_XLEN-1:0]     rvfi_rd_wdata_o,
  output logic [`RVFI_XLEN-1:0]     rvfi_mem_addr_o,
  output logic [`RVFI_XLEN/8-1:0]   rvfi_mem_rmask_o,
  output logic [`RVFI_XLEN/8-1:0]   rvfi_mem_wmask_o,
  output logic [`RVFI_XLEN-1:0]     rvfi_mem_rdata_o,
  output logic [`RVFI_XLEN-1:0]     rvfi_mem_wdata_o
);

  rvfi_pkg::id_rec_t        id_rec;
  rvfi_pkg::ex_rec_t        ex_rec;
  logic                     rd_valid;
  logic [`RVFI_XLEN-1:0]    pc_next;
  logic [`RVFI_ORDER_W-1:0] order_cnt_q;

  assign id_rec = id_q.pop_data;
  assign ex_rec = ex_q.pop_data;

  // Both heads belong to the instruction now in WB
  assign id_q.pop = wb_valid_i;
  assign ex_q.pop = wb_valid_i;

  assign rd_valid = rf_we_wb_i && (id_rec.insn.fields.rd != 5'd0);
  assign pc_next  = ex_rec.branch_taken ? ex_rec.branch_target
                                        : id_rec.pc + `RVFI_XLEN'(4);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvfi_valid_o <= 1'b0;
      order_cnt_q  <= '0;
    end else begin
      rvfi_valid_o <= wb_valid_i;
      if (wb_valid_i) begin
        order_cnt_q <= order_cnt_q + 1'b1;
      end
    end
  end

  // Record outputs hold their last value between retirements
  always_ff @(posedge clk_i) begin
    if (wb_valid_i) begin
      rvfi_order_o     <= order_cnt_q;
      rvfi_insn_o      <= id_rec.insn.raw;
      rvfi_pc_rdata_o  <= id_rec.pc;
      rvfi_pc_wdata_o  <= pc_next;
      rvfi_rs1_addr_o  <= id_rec.rs1_addr;
      rvfi_rs2_addr_o  <= id_rec.rs2_addr;
      rvfi_rs1_rdata_o <= id_rec.rs1_rdata;
      rvfi_rs2_rdata_o <= id_rec.rs2_rdata;
      rvfi_rd_addr_o   <= rd_valid ? id_rec.insn.fields.rd : 5'd0;
      rvfi_rd_wdata_o  <= rd_valid ? rf_wdata_wb_i : '0;
      rvfi_mem_addr_o  <= ex_rec.mem_addr;
      rvfi_mem_rmask_o <= ex_rec.mem_rmask;
      rvfi_mem_wmask_o <= ex_rec.mem_wmask;
      rvfi_mem_rdata_o <= rvfi_pkg::mask_bytes(lsu_rdata_wb_i, ex_rec.mem_rmask);
      rvfi_mem_wdata_o <= ex_rec.mem_wdata;
    end
  end

  // EX never runs ahead of ID, so the ID queue holds at least as many records
  a_id_ahead_of_ex: assert property (@(posedge clk_i) disable iff (reset_i)
    !ex_q.empty |-> !id_q.empty);

endmodule

// File: source/rvfi_settings.svh
// Retirement tracer build settings
// Data width, stage queue depth and order counter width
`ifndef RVFI_SETTINGS_SVH
`define RVFI_SETTINGS_SVH

// Data and address width
`define RVFI_XLEN 32

// Records held per stage queue
`define RVFI_QUEUE_DEPTH 4

// Retirement order counter width
`define RVFI_ORDER_W 64

`endif

// File: source/rvfi_stage_fifo.sv
// In-order stage record queue
// Circular buffer where a pushed record reaches the head one cycle later
`timescale 1ns/1ns

module rvfi_stage_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 4
) (
  input  logic        clk_i,
  input  logic        reset_i,
  rvfi_queue_if.store q
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign q.pop_data = mem[rd_ptr_q];
  assign q.empty    = (count_q == '0);
  assign q.full     = (count_q == CNT_W'(DEPTH));

  always_ff @(posedge clk_i) begin
    if (q.push) begin
      mem[wr_ptr_q] <= q.push_data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (q.push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (q.pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({q.push, q.pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // A pop in the same cycle frees the slot the push lands in
  a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    !(q.push && q.full && !q.pop));

  a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
    !(q.pop && q.empty));

endmodule

// File: source/rvfi_trace.sv
// Retirement tracer top level
// Queues ID and EX stage records and emits one RVFI trace record per WB strobe
`timescale 1ns/1ns
`include "rvfi_settings.svh"

module rvfi_trace (
  input  logic                     clk_i,
  input  logic                     reset_i,

  // ID stage
  input  logic                     id_valid_i,
  input  logic [`RVFI_XLEN-1:0]    pc_id_i,
  input  logic [31:0]              insn_id_i,
  input  logic [`RVFI_XLEN-1:0]    operand_a_fw_id_i,
  input  logic [`RVFI_XLEN-1:0]    operand_b_fw_id_i,

  // EX stage
  input  logic                     ex_valid_i,
  input  logic                     lsu_en_ex_i,
  input  logic                     lsu_we_ex_i,
  input  logic [1:0]               lsu_size_ex_i,
  input  logic [`RVFI_XLEN-1:0]    data_addr_ex_i,
  input  logic [`RVFI_XLEN-1:0]    data_wdata_ex_i,
  input  logic                     branch_taken_ex_i,
  input  logic [`RVFI_XLEN-1:0]    branch_target_ex_i,

  // WB stage
  input  logic                     wb_valid_i,
  input  logic                     rf_we_wb_i,
  input  logic [`RVFI_XLEN-1:0]    rf_wdata_wb_i,
  input  logic [`RVFI_XLEN-1:0]    lsu_rdata_wb_i,

  // Trace record
  output logic                     rvfi_valid_o,
  output logic [`RVFI_ORDER_W-1:0] rvfi_order_o,
  output logic [31:0]              rvfi_insn_o,
  output logic [`RVFI_XLEN-1:0]    rvfi_pc_rdata_o,
  output logic [`RVFI_XLEN-1:0]    rvfi_pc_wdata_o,
  output logic [4:0]               rvfi_rs1_addr_o,
  output logic [4:0]               rvfi_rs2_addr_o,
  output logic [`RVFI_XLEN-1:0]    rvfi_rs1_rdata_o,
  output logic [`RVFI_XLEN-1:0]    rvfi_rs2_rdata_o,
  output logic [4:0]               rvfi_rd_addr_o,
  output logic [`RVFI_XLEN-1:0]    rvfi_rd_wdata_o,
  output logic [`RVFI_XLEN-1:0]    rvfi_mem_addr_o,
  output logic [`RVFI_XLEN/8-1:0]  rvfi_mem_rmask_o,
  output logic [`RVFI_XLEN/8-1:0]  rvfi_mem_wmask_o,
  output logic [`RVFI_XLEN-1:0]    rvfi_mem_rdata_o,
  output logic [`RVFI_XLEN-1:0]    rvfi_mem_wdata_o
);

  localparam int ID_W = $bits(rvfi_pkg::id_rec_t);
  localparam int EX_W = $bits(rvfi_pkg::ex_rec_t);

  rvfi_queue_if #(.WIDTH(ID_W)) id_q ();
  rvfi_queue_if #(.WIDTH(EX_W)) ex_q ();

  rvfi_stage_fifo #(.WIDTH(ID_W), .DEPTH(`RVFI_QUEUE_DEPTH)) id_fifo_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .q       (id_q.store)
  );

  rvfi_stage_fifo #(.WIDTH(EX_W), .DEPTH(`RVFI_QUEUE_DEPTH)) ex_fifo_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .q       (ex_q.store)
  );

  rvfi_id_capture id_capture_i (
    .id_valid_i        (id_valid_i),
    .pc_id_i           (pc_id_i),
    .insn_id_i         (insn_id_i),
    .operand_a_fw_id_i (operand_a_fw_id_i),
    .operand_b_fw_id_i (operand_b_fw_id_i),
    .q                 (id_q.producer)
  );

  rvfi_ex_capture ex_capture_i (
    .clk_i              (clk_i),
    .ex_valid_i         (ex_valid_i),
    .lsu_en_ex_i        (lsu_en_ex_i),
    .lsu_we_ex_i        (lsu_we_ex_i),
    .lsu_size_ex_i      (rvfi_pkg::mem_size_e'(lsu_size_ex_i)),
    .data_addr_ex_i     (data_addr_ex_i),
    .data_wdata_ex_i    (data_wdata_ex_i),
    .branch_taken_ex_i  (branch_taken_ex_i),
    .branch_target_ex_i (branch_target_ex_i),
    .q                  (ex_q.producer)
  );

  rvfi_retire retire_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .wb_valid_i       (wb_valid_i),
    .rf_we_wb_i       (rf_we_wb_i),
    .rf_wdata_wb_i    (rf_wdata_wb_i),
    .lsu_rdata_wb_i   (lsu_rdata_wb_i),
    .id_q             (id_q.consumer),
    .ex_q             (ex_q.consumer),
    .rvfi_valid_o     (rvfi_valid_o),
    .rvfi_order_o     (rvfi_order_o),
    .rvfi_insn_o      (rvfi_insn_o),
    .rvfi_pc_rdata_o  (rvfi_pc_rdata_o),
    .rvfi_pc_wdata_o  (rvfi_pc_wdata_o),
    .rvfi_rs1_addr_o  (rvfi_rs1_addr_o),
    .rvfi_rs2_addr_o  (rvfi_rs2_addr_o),
    .rvfi_rs1_rdata_o (rvfi_rs1_rdata_o),
    .rvfi_rs2_rdata_o (rvfi_rs2_rdata_o),
    .rvfi_rd_addr_o   (rvfi_rd_addr_o),
    .rvfi_rd_wdata_o  (rvfi_rd_wdata_o),
    .rvfi_mem_addr_o  (rvfi_mem_addr_o),
    .rvfi_mem_rmask_o (rvfi_mem_rmask_o),
    .rvfi_mem_wmask_o (rvfi_mem_wmask_o),
    .rvfi_mem_rdata_o (rvfi_mem_rdata_o),
    .rvfi_mem_wdata_o (rvfi_mem_wdata_o)
  );

endmodule
